// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_user_processor -f sim.f \
    -Mdir obj_dir -o tb_user_processor &&
./obj_dir/tb_user_processor || exit 1

// ==== sim.f ====
src/soc_pkg.sv
src/uart_pkg.sv
src/mem_bus_if.sv
src/uart_ctrl_if.sv
src/icache.sv
src/data_bus.sv
src/uart_regs.sv
src/uart_core.sv
src/user_processor.sv
sim/tb_user_processor.sv

// ==== sim/tb_user_processor.sv ====
// Testbench for user_processor with instruction memory, cache tag, data RAM and UART models.
`timescale 1ns/10ps
`default_nettype none

module tb_user_processor import soc_pkg::*, uart_pkg::*; ();

    localparam int    CACHE_LINES    = 16;
    localparam int    DATA_WORDS     = 64;
    localparam int    BAUD_DIV_RESET = 8;
    localparam int    IDX_W          = $clog2(CACHE_LINES);
    localparam int    TIMEOUT        = 400;
    localparam word_t IMEM_KEY       = 32'h5EED_C0DE;

    logic  clk_i = 1'b0;
    logic  arst_n_i;
    logic  fetch_req_i;
    word_t fetch_addr_i;
    logic  fetch_rvalid_o;
    word_t fetch_data_o;
    logic  fetch_stall_o;
    logic  dmem_req_i;
    logic  dmem_we_i;
    word_t dmem_addr_i;
    word_t dmem_wdata_i;
    mask_t dmem_wmask_i;
    word_t dmem_rdata_o;
    logic  dmem_rvalid_o;
    logic  iomem_valid_o;
    word_t iomem_addr_o;
    logic  iomem_ready_i;
    word_t iomem_rdata_i;
    wire   uart_line;                  // TX looped back into RX.

    integer seed = 32'h51a8;
    logic   model_valid [CACHE_LINES];
    word_t  model_tag [CACHE_LINES];
    word_t  shadow [DATA_WORDS];

    always #50 clk_i = ~clk_i;

    user_processor #(
        .CACHE_LINES   (CACHE_LINES),
        .DATA_WORDS    (DATA_WORDS),
        .BAUD_DIV_RESET(BAUD_DIV_RESET)
    ) uut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_rvalid_o(fetch_rvalid_o),
        .fetch_data_o  (fetch_data_o),
        .fetch_stall_o (fetch_stall_o),
        .dmem_req_i    (dmem_req_i),
        .dmem_we_i     (dmem_we_i),
        .dmem_addr_i   (dmem_addr_i),
        .dmem_wdata_i  (dmem_wdata_i),
        .dmem_wmask_i  (dmem_wmask_i),
        .dmem_rdata_o  (dmem_rdata_o),
        .dmem_rvalid_o (dmem_rvalid_o),
        .iomem_valid_o (iomem_valid_o),
        .iomem_addr_o  (iomem_addr_o),
        .iomem_ready_i (iomem_ready_i),
        .iomem_rdata_i (iomem_rdata_i),
        .uart_tx_o     (uart_line),
        .uart_rx_i     (uart_line)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    function automatic word_t imem_word(input word_t addr);
        return addr ^ IMEM_KEY;
    endfunction

    function automatic word_t reg_addr(input reg_off_t off);
        return UART_BASE | (word_t'(off) << 2);
    endfunction

    task automatic write_data(input word_t addr, input word_t data, input mask_t mask);
        @(posedge clk_i);
        dmem_req_i   <= 1'b1;
        dmem_we_i    <= 1'b1;
        dmem_addr_i  <= addr;
        dmem_wdata_i <= data;
        dmem_wmask_i <= mask;
        @(posedge clk_i);
        dmem_req_i <= 1'b0;
        dmem_we_i  <= 1'b0;
    endtask

    task automatic read_data(input word_t addr, output word_t data);
        int lat;
        @(posedge clk_i);
        dmem_req_i  <= 1'b1;
        dmem_we_i   <= 1'b0;
        dmem_addr_i <= addr;
        @(posedge clk_i);
        dmem_req_i <= 1'b0;
        lat = 1;
        @(negedge clk_i);
        while (dmem_rvalid_o !== 1'b1) begin
            if (lat >= TIMEOUT) begin
                abort_run("Timeout waiting for dmem_rvalid_o after a data read.");
            end
            @(negedge clk_i);
            lat++;
        end
        if (lat != 1) begin
            abort_run($sformatf("Data read of %h answered after %0d cycles.", addr, lat));
        end
        data = dmem_rdata_o;
    endtask

    task automatic fetch_and_check(input word_t addr);
        int    idx;
        word_t tag;
        logic  hit;
        int    gap;
        int    lat;
        idx = int'((addr >> 2) % CACHE_LINES);
        tag = addr >> (IDX_W + 2);
        hit = model_valid[idx] && (model_tag[idx] == tag);
        @(posedge clk_i);
        fetch_req_i  <= 1'b1;
        fetch_addr_i <= addr;
        @(posedge clk_i);
        fetch_req_i <= 1'b0;
        @(negedge clk_i);
        if (hit) begin
            check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b1);
            check_flag("iomem_valid_o", iomem_valid_o, 1'b0);
        end else begin
            check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
            check_flag("iomem_valid_o", iomem_valid_o, 1'b1);
            check_flag("fetch_stall_o", fetch_stall_o, 1'b1);
            check_word("iomem_addr_o", iomem_addr_o, addr);
            gap = $random(seed) & 3;               // Memory wait states.
            for (int i = 0; i < gap; i++) begin
                @(negedge clk_i);
                check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
                check_flag("iomem_valid_o", iomem_valid_o, 1'b1);
                check_word("iomem_addr_o", iomem_addr_o, addr);
            end
            @(posedge clk_i);
            iomem_ready_i <= 1'b1;
            iomem_rdata_i <= imem_word(addr);
            @(posedge clk_i);
            iomem_ready_i <= 1'b0;
            lat = 0;
            @(negedge clk_i);
            while (fetch_rvalid_o !== 1'b1) begin
                if (lat >= TIMEOUT) begin
                    abort_run("Timeout waiting for fetch_rvalid_o after a refill.");
                end
                @(negedge clk_i);
                lat++;
            end
            if (lat != 0) begin
                abort_run($sformatf("Refill of %h answered %0d cycles late.", addr, lat));
            end
            check_flag("fetch_stall_o", fetch_stall_o, 1'b0);
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
        check_word("fetch_data_o", fetch_data_o, imem_word(addr));
    endtask

    task automatic decode_frame(input int div, output byte_t value);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (uart_line !== START_BIT) begin
            if (waited >= TIMEOUT) begin
                abort_run("Timeout waiting for a start bit on uart_tx_o.");
            end
            @(negedge clk_i);
            waited++;
        end
        repeat (div / 2) @(negedge clk_i);     // Move to mid-bit.
        check_flag("uart_tx_o start bit", uart_line, START_BIT);
        for (int b = 0; b < DATA_BITS; b++) begin
            repeat (div) @(negedge clk_i);
            value[b] = uart_line;
        end
        repeat (div) @(negedge clk_i);
        check_flag("uart_tx_o stop bit", uart_line, STOP_BIT);
    endtask

    initial begin
        word_t addr;
        word_t data;
        word_t rd;
        word_t baud;
        mask_t mask;
        byte_t sent;
        byte_t decoded;
        int    idx;
        int    polls;
        arst_n_i      = 1'b0;
        fetch_req_i   = 1'b0;
        fetch_addr_i  = '0;
        dmem_req_i    = 1'b0;
        dmem_we_i     = 1'b0;
        dmem_addr_i   = '0;
        dmem_wdata_i  = '0;
        dmem_wmask_i  = '0;
        iomem_ready_i = 1'b0;
        iomem_rdata_i = '0;
        for (int i = 0; i < CACHE_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag("uart_tx_o", uart_line, 1'b1);
        check_flag("iomem_valid_o", iomem_valid_o, 1'b0);
        check_flag("fetch_stall_o", fetch_stall_o, 1'b0);
        check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
        check_flag("dmem_rvalid_o", dmem_rvalid_o, 1'b0);

        for (int i = 0; i < 80; i++) begin
            fetch_and_check(word_t'($random(seed)) & 32'h0000_00FC);
        end
        fetch_and_check(32'h0000_0100);        // Same index, evicts each other.
        fetch_and_check(32'h0000_0140);
        fetch_and_check(32'h0000_0100);

        for (int w = 0; w < DATA_WORDS; w++) begin
            data = word_t'($random(seed));
            write_data(word_t'(w) << 2, data, 4'hF);
            shadow[w] = data;
        end
        for (int i = 0; i < 120; i++) begin
            addr = word_t'($random(seed)) & 32'h0000_03FC;
            idx  = int'((addr >> 2) % DATA_WORDS);
            if (($random(seed) & 1) == 1) begin
                data = word_t'($random(seed));
                mask = mask_t'($random(seed));
                write_data(addr, data, mask);
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) begin
                        shadow[idx][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end else begin
                read_data(addr, rd);
                check_word("dmem_rdata_o", rd, shadow[idx]);
            end
        end

        baud = word_t'(4 + ($random(seed) & 7));
        write_data(reg_addr(REG_BAUD), baud, 4'hF);
        read_data(reg_addr(REG_BAUD), rd);
        check_word("dmem_rdata_o baud", rd, baud);
        read_data(reg_addr(REG_STATUS), rd);
        check_flag("status tx_busy", rd[STAT_TX_BUSY], 1'b0);
        sent = byte_t'($random(seed));
        write_data(reg_addr(REG_TXDATA), word_t'(sent), 4'hF);
        fork
            decode_frame(int'(baud), decoded);
            begin
                repeat (3) @(posedge clk_i);
                read_data(reg_addr(REG_STATUS), rd);
                check_flag("status tx_busy", rd[STAT_TX_BUSY], 1'b1);
                write_data(reg_addr(REG_TXDATA), word_t'(~sent), 4'hF);  // Must be dropped.
            end
        join
        check_byte("uart_tx_o frame", decoded, sent);

        polls = 0;
        read_data(reg_addr(REG_STATUS), rd);
        while (rd[STAT_RX_VALID] !== 1'b1) begin
            if (polls >= TIMEOUT) begin
                abort_run("Timeout waiting for rx_valid after the looped frame.");
            end
            read_data(reg_addr(REG_STATUS), rd);
            polls++;
        end
        for (int c = 0; c < 12 * int'(baud); c++) begin
            @(negedge clk_i);
            check_flag("uart_tx_o idle", uart_line, 1'b1);
        end
        read_data(reg_addr(REG_STATUS), rd);
        check_flag("status tx_busy", rd[STAT_TX_BUSY], 1'b0);
        check_flag("status rx_valid", rd[STAT_RX_VALID], 1'b1);
        read_data(reg_addr(REG_RXDATA), rd);
        check_byte("dmem_rdata_o rx byte", byte_t'(rd), sent);
        read_data(reg_addr(REG_STATUS), rd);
        check_flag("status rx_valid", rd[STAT_RX_VALID], 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/data_bus.sv ====
// Data address decoder, byte-masked data RAM and read data routing.
`timescale 1ns/10ps
`default_nettype none

module data_bus import soc_pkg::*; #(
    parameter int DATA_WORDS = 64
) (
    input  wire        clk_i,
    input  wire        arst_n_i,
    input  wire        dmem_req_i,
    input  wire        dmem_we_i,
    input  wire word_t dmem_addr_i,
    input  wire word_t dmem_wdata_i,
    input  wire mask_t dmem_wmask_i,
    output word_t      dmem_rdata_o,
    output logic       dmem_rvalid_o,
    mem_bus_if.master  uart_bus
);

    localparam int RAM_AW = $clog2(DATA_WORDS);

    word_t             ram [DATA_WORDS];
    logic [RAM_AW-1:0] ram_idx;
    logic              uart_sel;
    logic              rd_ram_q;
    word_t             ram_rdata_q;

    assign uart_sel = dmem_addr_i[31:UART_SEL_LSB] == UART_BASE[31:UART_SEL_LSB];
    assign ram_idx  = RAM_AW'(dmem_addr_i[31:2] % DATA_WORDS);

    assign uart_bus.req   = dmem_req_i & uart_sel;
    assign uart_bus.we    = dmem_we_i;
    assign uart_bus.addr  = dmem_addr_i;
    assign uart_bus.wdata = dmem_wdata_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ram_q <= 1'b0;
        end else begin
            rd_ram_q <= dmem_req_i & ~dmem_we_i & ~uart_sel;  // RAM read target.
        end
    end

    always_ff @(posedge clk_i) begin
        if (dmem_req_i && !uart_sel) begin
            if (dmem_we_i) begin
                for (int b = 0; b < $bits(mask_t); b++) begin
                    if (dmem_wmask_i[b]) begin
                        ram[ram_idx][8*b +: 8] <= dmem_wdata_i[8*b +: 8];
                    end
                end
            end else begin
                ram_rdata_q <= ram[ram_idx];
            end
        end
    end

    assign dmem_rvalid_o = rd_ram_q | uart_bus.rvalid;
    assign dmem_rdata_o  = rd_ram_q ? ram_rdata_q : uart_bus.rdata;

endmodule

`default_nettype wire

// ==== src/icache.sv ====
// Direct-mapped instruction cache with single-word refill over iomem.
`timescale 1ns/10ps
`default_nettype none

module icache import soc_pkg::*; #(
    parameter int CACHE_LINES = 16
) (
    input  wire        clk_i,
    input  wire        arst_n_i,
    input  wire        fetch_req_i,
    input  wire word_t fetch_addr_i,
    output logic       fetch_rvalid_o,
    output word_t      fetch_data_o,
    output logic       fetch_stall_o,
    output logic       iomem_valid_o,
    output word_t      iomem_addr_o,
    input  wire        iomem_ready_i,
    input  wire word_t iomem_rdata_i
);

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = 30 - IDX_W;

    logic [TAG_W-1:0]       tag_mem [CACHE_LINES];
    word_t                  data_mem [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    logic                   refill_q;
    word_t                  miss_addr_q;
    logic [IDX_W-1:0]       req_idx;
    logic [TAG_W-1:0]       req_tag;
    logic [IDX_W-1:0]       miss_idx;
    logic [TAG_W-1:0]       miss_tag;
    logic                   accept;
    logic                   hit;
    logic                   fill_done;

    assign req_idx   = fetch_addr_i[IDX_W+1:2];
    assign req_tag   = fetch_addr_i[31:IDX_W+2];
    assign miss_idx  = miss_addr_q[IDX_W+1:2];
    assign miss_tag  = miss_addr_q[31:IDX_W+2];
    assign accept    = fetch_req_i & ~refill_q;   // Ignored while stalled.
    assign hit       = valid_q[req_idx] & (tag_mem[req_idx] == req_tag);
    assign fill_done = refill_q & iomem_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q        <= '0;
            refill_q       <= 1'b0;
            fetch_rvalid_o <= 1'b0;
        end else begin
            fetch_rvalid_o <= (accept & hit) | fill_done;
            if (accept && !hit) begin
                refill_q <= 1'b1;
            end else if (fill_done) begin
                refill_q          <= 1'b0;
                valid_q[miss_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !hit) begin
            miss_addr_q <= fetch_addr_i;
        end
        if (fill_done) begin
            tag_mem[miss_idx]  <= miss_tag;
            data_mem[miss_idx] <= iomem_rdata_i;
            fetch_data_o       <= iomem_rdata_i;   // Forward the refilled word.
        end else if (accept && hit) begin
            fetch_data_o <= data_mem[req_idx];
        end
    end

    assign iomem_valid_o = refill_q;  // Held with a stable address until ready.
    assign iomem_addr_o  = miss_addr_q;
    assign fetch_stall_o = refill_q;

endmodule

`default_nettype wire

// ==== src/mem_bus_if.sv ====
// Strobe request bus between the data bus and the UART register block.
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if import soc_pkg::*; ();

    word_t addr;
    word_t wdata;
    logic  req;      // Single-cycle strobe.
    logic  we;
    word_t rdata;
    logic  rvalid;   // One cycle after a read request.

    modport master (
        output addr, wdata, req, we,
        input  rdata, rvalid
    );

    modport slave (
        input  addr, wdata, req, we,
        output rdata, rvalid
    );

endinterface

`default_nettype wire

// ==== src/soc_pkg.sv ====
// Bus word types, UART address window and UART register offsets.
`default_nettype none

package soc_pkg;

    typedef logic [31:0] word_t;     // Bus word.
    typedef logic [3:0]  mask_t;     // Byte write mask.

    // UART window; the upper 20 address bits select it.
    localparam word_t UART_BASE    = 32'h2000_0000;
    localparam int    UART_SEL_LSB = 12;

    typedef logic [1:0] reg_off_t;   // Register offset, address bits 3:2.

    localparam reg_off_t REG_TXDATA = 2'd0;  // Write only.
    localparam reg_off_t REG_RXDATA = 2'd1;  // Read clears rx_valid.
    localparam reg_off_t REG_STATUS = 2'd2;
    localparam reg_off_t REG_BAUD   = 2'd3;  // Clocks per bit.

endpackage

`default_nettype wire

// ==== src/uart_core.sv ====
// UART transmit and receive shift engines with baud counters.
`timescale 1ns/10ps
`default_nettype none

module uart_core import soc_pkg::*, uart_pkg::*; (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire         uart_rx_i,
    output logic        uart_tx_o,
    uart_ctrl_if.engine ctrl
);

    localparam int BIT_W = $clog2(FRAME_BITS);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 1);

    logic                  tx_busy_q;
    word_t                 tx_cnt_q;
    logic [BIT_W-1:0]      tx_bits_q;
    logic [FRAME_BITS-1:0] tx_shift_q;
    logic                  tx_tick;
    logic                  rx_s1_q;
    logic                  rx_s2_q;
    logic                  rx_prev_q;
    logic                  rx_busy_q;
    word_t                 rx_cnt_q;
    logic [BIT_W-1:0]      rx_bits_q;
    logic [FRAME_BITS-1:0] rx_shift_q;
    logic                  rx_strobe_q;
    byte_t                 rx_byte_q;
    logic                  rx_sample;
    logic                  rx_last;
    logic                  frame_ok;

    assign tx_tick   = (tx_cnt_q + 32'd1) >= ctrl.baud_div;
    assign rx_sample = rx_busy_q & (rx_cnt_q == '0);
    assign rx_last   = rx_sample & (rx_bits_q == LAST_BIT);
    assign frame_ok  = (rx_s2_q == STOP_BIT) & (rx_shift_q[1] == START_BIT);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_busy_q  <= 1'b0;
            tx_cnt_q   <= '0;
            tx_bits_q  <= '0;
            tx_shift_q <= '1;
        end else if (!tx_busy_q) begin
            if (ctrl.tx_start) begin
                tx_busy_q  <= 1'b1;
                tx_shift_q <= {STOP_BIT, ctrl.tx_byte, START_BIT};  // LSB first.
                tx_cnt_q   <= '0;
                tx_bits_q  <= '0;
            end
        end else if (tx_tick) begin
            tx_cnt_q <= '0;
            if (tx_bits_q == LAST_BIT) begin
                tx_busy_q <= 1'b0;   // Stop bit done.
            end else begin
                tx_shift_q <= {STOP_BIT, tx_shift_q[FRAME_BITS-1:1]};
                tx_bits_q  <= tx_bits_q + 1'b1;
            end
        end else begin
            tx_cnt_q <= tx_cnt_q + 32'd1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_s1_q     <= STOP_BIT;
            rx_s2_q     <= STOP_BIT;
            rx_prev_q   <= STOP_BIT;
            rx_busy_q   <= 1'b0;
            rx_cnt_q    <= '0;
            rx_bits_q   <= '0;
            rx_strobe_q <= 1'b0;
        end else begin
            rx_s1_q     <= uart_rx_i;
            rx_s2_q     <= rx_s1_q;
            rx_prev_q   <= rx_s2_q;
            rx_strobe_q <= rx_last & frame_ok;
            if (!rx_busy_q) begin
                if (rx_prev_q && !rx_s2_q) begin   // Start edge.
                    rx_busy_q <= 1'b1;
                    rx_cnt_q  <= ctrl.baud_div >> 1;
                    rx_bits_q <= '0;
                end
            end else if (rx_sample) begin
                rx_cnt_q  <= ctrl.baud_div - 32'd1;
                rx_bits_q <= rx_bits_q + 1'b1;
                if (rx_last) begin
                    rx_busy_q <= 1'b0;
                end
            end else begin
                rx_cnt_q <= rx_cnt_q - 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_sample) begin
            rx_shift_q <= {rx_s2_q, rx_shift_q[FRAME_BITS-1:1]};
        end
        if (rx_last) begin
            rx_byte_q <= rx_shift_q[FRAME_BITS-1:2];
        end
    end

    assign uart_tx_o      = tx_busy_q ? tx_shift_q[0] : STOP_BIT;
    assign ctrl.tx_busy   = tx_busy_q;
    assign ctrl.rx_byte   = rx_byte_q;
    assign ctrl.rx_strobe = rx_strobe_q;

endmodule

`default_nettype wire

// ==== src/uart_ctrl_if.sv ====
// Control link between the UART register block and the serial engine.
`timescale 1ns/10ps
`default_nettype none

interface uart_ctrl_if import soc_pkg::*, uart_pkg::*; ();

    logic  tx_start;   // Strobe, only when tx_busy is low.
    byte_t tx_byte;
    word_t baud_div;
    logic  tx_busy;
    byte_t rx_byte;
    logic  rx_strobe;  // One cycle per received byte.

    modport ctrl (
        output tx_start, tx_byte, baud_div,
        input  tx_busy, rx_byte, rx_strobe
    );

    modport engine (
        input  tx_start, tx_byte, baud_div,
        output tx_busy, rx_byte, rx_strobe
    );

endinterface

`default_nettype wire

// ==== src/uart_pkg.sv ====
// UART frame constants, status bit positions and byte type.
`default_nettype none

package uart_pkg;

    localparam int DATA_BITS  = 8;
    localparam int FRAME_BITS = DATA_BITS + 2;  // Start, data, stop; no parity.

    typedef logic [DATA_BITS-1:0] byte_t;

    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;  // Also the idle line level.

    localparam int STAT_TX_BUSY  = 0;
    localparam int STAT_RX_VALID = 1;

endpackage

`default_nettype wire

// ==== src/uart_regs.sv ====
// UART register block with divisor, receive buffer and status flags.
`timescale 1ns/10ps
`default_nettype none

module uart_regs import soc_pkg::*, uart_pkg::*; #(
    parameter int BAUD_DIV_RESET = 8
) (
    input  wire        clk_i,
    input  wire        arst_n_i,
    mem_bus_if.slave   bus,
    uart_ctrl_if.ctrl  ctrl
);

    word_t    baud_q;
    byte_t    rx_buf_q;
    logic     rx_valid_q;
    word_t    rdata_q;
    logic     rvalid_q;
    reg_off_t offset;
    logic     rd_req;
    logic     wr_req;
    word_t    status;

    assign offset = bus.addr[3:2];
    assign rd_req = bus.req & ~bus.we;
    assign wr_req = bus.req & bus.we;

    always_comb begin
        status                = '0;
        status[STAT_TX_BUSY]  = ctrl.tx_busy;
        status[STAT_RX_VALID] = rx_valid_q;
    end

    // Writes during a transmission are dropped.
    assign ctrl.tx_start = wr_req & (offset == REG_TXDATA) & ~ctrl.tx_busy;
    assign ctrl.tx_byte  = byte_t'(bus.wdata);
    assign ctrl.baud_div = baud_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            baud_q     <= word_t'(BAUD_DIV_RESET);
            rx_valid_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            rvalid_q <= rd_req;
            if (wr_req && offset == REG_BAUD) begin
                baud_q <= bus.wdata;
            end
            if (ctrl.rx_strobe) begin
                rx_valid_q <= 1'b1;   // New byte wins over a clear.
            end else if (rd_req && offset == REG_RXDATA) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.rx_strobe) begin
            rx_buf_q <= ctrl.rx_byte;
        end
        if (rd_req) begin
            case (offset)
                REG_RXDATA: rdata_q <= word_t'(rx_buf_q);
                REG_STATUS: rdata_q <= status;
                REG_BAUD:   rdata_q <= baud_q;
                default:    rdata_q <= '0;   // TXDATA reads as zero.
            endcase
        end
    end

    assign bus.rdata  = rdata_q;
    assign bus.rvalid = rvalid_q;

endmodule

`default_nettype wire

// ==== src/user_processor.sv ====
// Top level joining the instruction cache, data bus and UART.
`timescale 1ns/10ps
`default_nettype none

module user_processor import soc_pkg::*; #(
    parameter int CACHE_LINES    = 16,
    parameter int DATA_WORDS     = 64,
    parameter int BAUD_DIV_RESET = 8
) (
    input  wire        clk_i,
    input  wire        arst_n_i,
    input  wire        fetch_req_i,
    input  wire word_t fetch_addr_i,
    output logic       fetch_rvalid_o,
    output word_t      fetch_data_o,
    output logic       fetch_stall_o,
    input  wire        dmem_req_i,
    input  wire        dmem_we_i,
    input  wire word_t dmem_addr_i,
    input  wire word_t dmem_wdata_i,
    input  wire mask_t dmem_wmask_i,
    output word_t      dmem_rdata_o,
    output logic       dmem_rvalid_o,
    output logic       iomem_valid_o,
    output word_t      iomem_addr_o,
    input  wire        iomem_ready_i,
    input  wire word_t iomem_rdata_i,
    output logic       uart_tx_o,
    input  wire        uart_rx_i
);

    mem_bus_if   uart_bus ();
    uart_ctrl_if uart_ctrl ();

    icache #(.CACHE_LINES(CACHE_LINES)) u_icache (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_rvalid_o(fetch_rvalid_o),
        .fetch_data_o  (fetch_data_o),
        .fetch_stall_o (fetch_stall_o),
        .iomem_valid_o (iomem_valid_o),
        .iomem_addr_o  (iomem_addr_o),
        .iomem_ready_i (iomem_ready_i),
        .iomem_rdata_i (iomem_rdata_i)
    );

    data_bus #(.DATA_WORDS(DATA_WORDS)) u_data_bus (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dmem_req_i   (dmem_req_i),
        .dmem_we_i    (dmem_we_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_wdata_i (dmem_wdata_i),
        .dmem_wmask_i (dmem_wmask_i),
        .dmem_rdata_o (dmem_rdata_o),
        .dmem_rvalid_o(dmem_rvalid_o),
        .uart_bus     (uart_bus.master)
    );

    uart_regs #(.BAUD_DIV_RESET(BAUD_DIV_RESET)) u_uart_regs (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .bus     (uart_bus.slave),
        .ctrl    (uart_ctrl.ctrl)
    );

    uart_core u_uart_core (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .uart_rx_i(uart_rx_i),
        .uart_tx_o(uart_tx_o),
        .ctrl     (uart_ctrl.engine)
    );

endmodule

`default_nettype wire
